//--- ctrl_encoder.sv
`timescale 1ns/1ps

module ctrl_encoder (
    input  ctrl_pkg::ctrl_state_t state,
    input  ctrl_pkg::decoded_t    instr,
    input  ctrl_pkg::cause_t      cause,
    input  logic                  zero,
    output ctrl_pkg::mem_ctrl_t   mem_ctrl,
    output ctrl_pkg::reg_ctrl_t   reg_ctrl,
    output ctrl_pkg::alu_ctrl_t   alu_ctrl,
    output ctrl_pkg::pc_ctrl_t    pc_ctrl
);

    logic is_branch;
    logic uses_reg_b;
    logic branch_taken;

    assign is_branch  = (instr.cls == ctrl_pkg::CLS_BEQ) || (instr.cls == ctrl_pkg::CLS_BNE);
    assign uses_reg_b = is_branch || (instr.cls == ctrl_pkg::CLS_ALU_R);

    assign branch_taken = ((instr.cls == ctrl_pkg::CLS_BEQ) && zero) ||
                          ((instr.cls == ctrl_pkg::CLS_BNE) && !zero);

    always_comb begin
        mem_ctrl.addr_sel = ctrl_pkg::ADDR_SEL_PC;
        mem_ctrl.mem_wr   = 1'b0;
        mem_ctrl.ir_wr    = 1'b0;

        reg_ctrl.reg_wr  = 1'b0;
        reg_ctrl.reg_dst = ctrl_pkg::REG_DST_RT;
        reg_ctrl.wb_sel  = ctrl_pkg::WB_SEL_ALU_OUT;
        reg_ctrl.wr_a    = 1'b0;
        reg_ctrl.wr_b    = 1'b0;

        alu_ctrl.src_a      = ctrl_pkg::SRC_A_PC;
        alu_ctrl.src_b      = ctrl_pkg::SRC_B_REG_B;
        alu_ctrl.alu_op     = ctrl_pkg::ALU_OP_ADD;
        alu_ctrl.alu_out_wr = 1'b0;

        pc_ctrl.pc_wr  = 1'b0;
        pc_ctrl.pc_src = ctrl_pkg::PC_SRC_ALU_RESULT;
        pc_ctrl.epc_wr = 1'b0;
        pc_ctrl.cause  = ctrl_pkg::CAUSE_OVERFLOW;

        case (state)
            ctrl_pkg::ST_FETCH_ADDR: begin
                // ALU out gets PC + 4
                alu_ctrl.src_a      = ctrl_pkg::SRC_A_PC;
                alu_ctrl.src_b      = ctrl_pkg::SRC_B_FOUR;
                alu_ctrl.alu_op     = ctrl_pkg::ALU_OP_ADD;
                alu_ctrl.alu_out_wr = 1'b1;
            end

            ctrl_pkg::ST_FETCH_IR: begin
                mem_ctrl.addr_sel = ctrl_pkg::ADDR_SEL_PC;
                mem_ctrl.ir_wr    = 1'b1;
                pc_ctrl.pc_wr     = 1'b1;
                pc_ctrl.pc_src    = ctrl_pkg::PC_SRC_ALU_OUT;
            end

            ctrl_pkg::ST_DECODE: begin
                // Register read plus branch target into ALU out
                reg_ctrl.wr_a       = 1'b1;
                reg_ctrl.wr_b       = 1'b1;
                alu_ctrl.src_a      = ctrl_pkg::SRC_A_PC;
                alu_ctrl.src_b      = ctrl_pkg::SRC_B_IMM_SHIFTED;
                alu_ctrl.alu_op     = ctrl_pkg::ALU_OP_ADD;
                alu_ctrl.alu_out_wr = 1'b1;
            end

            ctrl_pkg::ST_EXEC: begin
                alu_ctrl.src_a  = ctrl_pkg::SRC_A_REG_A;
                alu_ctrl.src_b  = uses_reg_b ? ctrl_pkg::SRC_B_REG_B : ctrl_pkg::SRC_B_IMM;
                alu_ctrl.alu_op = instr.alu_op;
                // Branches keep the target in ALU out
                alu_ctrl.alu_out_wr = !is_branch;
            end

            ctrl_pkg::ST_WRITEBACK: begin
                reg_ctrl.reg_wr  = 1'b1;
                reg_ctrl.wb_sel  = ctrl_pkg::WB_SEL_ALU_OUT;
                reg_ctrl.reg_dst = (instr.cls == ctrl_pkg::CLS_ALU_R) ?
                                   ctrl_pkg::REG_DST_RD : ctrl_pkg::REG_DST_RT;
            end

            ctrl_pkg::ST_MEM_ACCESS: begin
                mem_ctrl.addr_sel = ctrl_pkg::ADDR_SEL_ALU_OUT;
                mem_ctrl.mem_wr   = (instr.cls == ctrl_pkg::CLS_STORE);
            end

            // Address held while the read completes
            ctrl_pkg::ST_MEM_WAIT: mem_ctrl.addr_sel = ctrl_pkg::ADDR_SEL_ALU_OUT;

            ctrl_pkg::ST_MEM_READBACK: begin
                reg_ctrl.reg_wr  = 1'b1;
                reg_ctrl.wb_sel  = ctrl_pkg::WB_SEL_MDR;
                reg_ctrl.reg_dst = ctrl_pkg::REG_DST_RT;
            end

            ctrl_pkg::ST_BRANCH: begin
                // Compare stays on the ALU so zero is valid this cycle
                alu_ctrl.src_a  = ctrl_pkg::SRC_A_REG_A;
                alu_ctrl.src_b  = ctrl_pkg::SRC_B_REG_B;
                alu_ctrl.alu_op = instr.alu_op;
                pc_ctrl.pc_wr   = branch_taken;
                pc_ctrl.pc_src  = ctrl_pkg::PC_SRC_ALU_OUT;
            end

            ctrl_pkg::ST_LINK: begin
                reg_ctrl.reg_wr  = 1'b1;
                reg_ctrl.wb_sel  = ctrl_pkg::WB_SEL_PC;
                reg_ctrl.reg_dst = ctrl_pkg::REG_DST_RA;
            end

            ctrl_pkg::ST_JUMP: begin
                pc_ctrl.pc_wr  = 1'b1;
                pc_ctrl.pc_src = (instr.cls == ctrl_pkg::CLS_JR) ?
                                 ctrl_pkg::PC_SRC_REG_A : ctrl_pkg::PC_SRC_JUMP_TARGET;
            end

            ctrl_pkg::ST_TRAP: begin
                pc_ctrl.epc_wr = 1'b1;
                pc_ctrl.pc_wr  = 1'b1;
                pc_ctrl.pc_src = ctrl_pkg::PC_SRC_TRAP_VECTOR;
                pc_ctrl.cause  = cause;
            end

            default: begin
            end
        endcase
    end

endmodule

//--- ctrl_pkg.sv
package ctrl_pkg;

    typedef logic [5:0] op_field_t;
    typedef logic [2:0] alu_op_t;
    typedef logic [2:0] addr_sel_t;
    typedef logic [2:0] wb_sel_t;
    typedef logic [1:0] reg_dst_t;
    typedef logic [1:0] src_a_t;
    typedef logic [2:0] src_b_t;
    typedef logic [2:0] pc_src_t;
    typedef logic [1:0] cause_t;

    // ALU operations as the datapath ALU expects them
    localparam alu_op_t ALU_OP_ADD = 3'b001;
    localparam alu_op_t ALU_OP_SUB = 3'b010;
    localparam alu_op_t ALU_OP_AND = 3'b011;
    localparam alu_op_t ALU_OP_OR  = 3'b100;
    localparam alu_op_t ALU_OP_SLT = 3'b101;

    localparam addr_sel_t ADDR_SEL_PC      = 3'b000;
    localparam addr_sel_t ADDR_SEL_ALU_OUT = 3'b100;

    localparam wb_sel_t WB_SEL_MDR     = 3'b010;
    localparam wb_sel_t WB_SEL_ALU_OUT = 3'b011;
    localparam wb_sel_t WB_SEL_PC      = 3'b110;

    localparam reg_dst_t REG_DST_RT = 2'b00;
    localparam reg_dst_t REG_DST_RD = 2'b01;
    localparam reg_dst_t REG_DST_RA = 2'b10;

    localparam src_a_t SRC_A_PC    = 2'b00;
    localparam src_a_t SRC_A_REG_A = 2'b10;

    localparam src_b_t SRC_B_REG_B       = 3'b000;
    localparam src_b_t SRC_B_FOUR        = 3'b001;
    localparam src_b_t SRC_B_IMM         = 3'b010;
    localparam src_b_t SRC_B_IMM_SHIFTED = 3'b011;

    localparam pc_src_t PC_SRC_ALU_RESULT  = 3'b000;
    localparam pc_src_t PC_SRC_ALU_OUT     = 3'b001;
    localparam pc_src_t PC_SRC_REG_A       = 3'b010;
    localparam pc_src_t PC_SRC_JUMP_TARGET = 3'b011;
    localparam pc_src_t PC_SRC_TRAP_VECTOR = 3'b100;

    localparam cause_t CAUSE_OVERFLOW = 2'd0;
    localparam cause_t CAUSE_ILLEGAL  = 2'd2;

    localparam op_field_t OP_RTYPE = 6'b000000;
    localparam op_field_t OP_LW    = 6'b100011;
    localparam op_field_t OP_SW    = 6'b101011;
    localparam op_field_t OP_ADDI  = 6'b001000;
    localparam op_field_t OP_ANDI  = 6'b001100;
    localparam op_field_t OP_ORI   = 6'b001101;
    localparam op_field_t OP_SLTI  = 6'b001010;
    localparam op_field_t OP_BEQ   = 6'b000100;
    localparam op_field_t OP_BNE   = 6'b000101;
    localparam op_field_t OP_J     = 6'b000010;
    localparam op_field_t OP_JAL   = 6'b000011;

    localparam op_field_t FN_ADD = 6'b100000;
    localparam op_field_t FN_SUB = 6'b100010;
    localparam op_field_t FN_AND = 6'b100100;
    localparam op_field_t FN_OR  = 6'b100101;
    localparam op_field_t FN_SLT = 6'b101010;
    localparam op_field_t FN_JR  = 6'b001000;

    typedef enum logic [3:0] {
        CLS_ALU_R,
        CLS_ALU_I,
        CLS_LOAD,
        CLS_STORE,
        CLS_BEQ,
        CLS_BNE,
        CLS_J,
        CLS_JAL,
        CLS_JR,
        CLS_ILLEGAL
    } instr_class_t;

    typedef enum logic [3:0] {
        ST_FETCH_ADDR,
        ST_FETCH_IR,
        ST_DECODE,
        ST_EXEC,
        ST_WRITEBACK,
        ST_MEM_ACCESS,
        ST_MEM_WAIT,
        ST_MEM_READBACK,
        ST_BRANCH,
        ST_LINK,
        ST_JUMP,
        ST_TRAP
    } ctrl_state_t;

    typedef struct packed {
        instr_class_t cls;
        alu_op_t      alu_op;
        logic         ovf_trap;
    } decoded_t;

    typedef struct packed {
        logic overflow;
        logic zero;
    } alu_flags_t;

    typedef struct packed {
        addr_sel_t addr_sel;
        logic      mem_wr;
        logic      ir_wr;
    } mem_ctrl_t;

    typedef struct packed {
        logic     reg_wr;
        reg_dst_t reg_dst;
        wb_sel_t  wb_sel;
        logic     wr_a;
        logic     wr_b;
    } reg_ctrl_t;

    typedef struct packed {
        src_a_t  src_a;
        src_b_t  src_b;
        alu_op_t alu_op;
        logic    alu_out_wr;
    } alu_ctrl_t;

    typedef struct packed {
        logic    pc_wr;
        pc_src_t pc_src;
        logic    epc_wr;
        cause_t  cause;
    } pc_ctrl_t;

endpackage

//--- ctrl_top.sv
`timescale 1ns/1ps

module ctrl_top (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrl_pkg::op_field_t  opcode,
    input  ctrl_pkg::op_field_t  funct,
    input  ctrl_pkg::alu_flags_t flags,
    output ctrl_pkg::mem_ctrl_t  mem_ctrl,
    output ctrl_pkg::reg_ctrl_t  reg_ctrl,
    output ctrl_pkg::alu_ctrl_t  alu_ctrl,
    output ctrl_pkg::pc_ctrl_t   pc_ctrl
);

    ctrl_pkg::decoded_t    decoded;
    ctrl_pkg::decoded_t    instr;
    ctrl_pkg::ctrl_state_t state;
    ctrl_pkg::cause_t      cause;

    instr_decoder u_decoder (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    // Overflow only matters to the sequencer
    seq_fsm u_seq (
        .clk      (clk),
        .reset    (reset),
        .decoded  (decoded),
        .overflow (flags.overflow),
        .state    (state),
        .instr    (instr),
        .cause    (cause)
    );

    ctrl_encoder u_encoder (
        .state    (state),
        .instr    (instr),
        .cause    (cause),
        .zero     (flags.zero),
        .mem_ctrl (mem_ctrl),
        .reg_ctrl (reg_ctrl),
        .alu_ctrl (alu_ctrl),
        .pc_ctrl  (pc_ctrl)
    );

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  ctrl_pkg::op_field_t opcode,
    input  ctrl_pkg::op_field_t funct,
    output ctrl_pkg::decoded_t  decoded
);

    always_comb begin
        decoded.cls      = ctrl_pkg::CLS_ILLEGAL;
        decoded.alu_op   = ctrl_pkg::ALU_OP_ADD;
        decoded.ovf_trap = 1'b0;

        case (opcode)
            ctrl_pkg::OP_RTYPE: begin
                decoded.cls = ctrl_pkg::CLS_ALU_R;
                case (funct)
                    ctrl_pkg::FN_ADD: begin
                        decoded.alu_op   = ctrl_pkg::ALU_OP_ADD;
                        decoded.ovf_trap = 1'b1;
                    end
                    ctrl_pkg::FN_SUB: begin
                        decoded.alu_op   = ctrl_pkg::ALU_OP_SUB;
                        decoded.ovf_trap = 1'b1;
                    end
                    ctrl_pkg::FN_AND: decoded.alu_op = ctrl_pkg::ALU_OP_AND;
                    ctrl_pkg::FN_OR:  decoded.alu_op = ctrl_pkg::ALU_OP_OR;
                    ctrl_pkg::FN_SLT: decoded.alu_op = ctrl_pkg::ALU_OP_SLT;
                    ctrl_pkg::FN_JR:  decoded.cls    = ctrl_pkg::CLS_JR;
                    default:          decoded.cls    = ctrl_pkg::CLS_ILLEGAL;
                endcase
            end
            ctrl_pkg::OP_ADDI: begin
                decoded.cls      = ctrl_pkg::CLS_ALU_I;
                decoded.ovf_trap = 1'b1;
            end
            ctrl_pkg::OP_ANDI: begin
                decoded.cls    = ctrl_pkg::CLS_ALU_I;
                decoded.alu_op = ctrl_pkg::ALU_OP_AND;
            end
            ctrl_pkg::OP_ORI: begin
                decoded.cls    = ctrl_pkg::CLS_ALU_I;
                decoded.alu_op = ctrl_pkg::ALU_OP_OR;
            end
            ctrl_pkg::OP_SLTI: begin
                decoded.cls    = ctrl_pkg::CLS_ALU_I;
                decoded.alu_op = ctrl_pkg::ALU_OP_SLT;
            end
            // Address calculation is base plus offset
            ctrl_pkg::OP_LW: decoded.cls = ctrl_pkg::CLS_LOAD;
            ctrl_pkg::OP_SW: decoded.cls = ctrl_pkg::CLS_STORE;
            // Branches compare by subtraction
            ctrl_pkg::OP_BEQ: begin
                decoded.cls    = ctrl_pkg::CLS_BEQ;
                decoded.alu_op = ctrl_pkg::ALU_OP_SUB;
            end
            ctrl_pkg::OP_BNE: begin
                decoded.cls    = ctrl_pkg::CLS_BNE;
                decoded.alu_op = ctrl_pkg::ALU_OP_SUB;
            end
            ctrl_pkg::OP_J:   decoded.cls = ctrl_pkg::CLS_J;
            ctrl_pkg::OP_JAL: decoded.cls = ctrl_pkg::CLS_JAL;
            default:          decoded.cls = ctrl_pkg::CLS_ILLEGAL;
        endcase
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator

verilator --binary --timing --assert --top-module tb_ctrl -f vlog.f -o tb_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ctrl_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

//--- seq_fsm.sv
`timescale 1ns/1ps

module seq_fsm (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_pkg::decoded_t    decoded,
    input  logic                  overflow,
    output ctrl_pkg::ctrl_state_t state,
    output ctrl_pkg::decoded_t    instr,
    output ctrl_pkg::cause_t      cause
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ctrl_pkg::ST_FETCH_ADDR;
            instr <= '0;
            cause <= ctrl_pkg::CAUSE_OVERFLOW;
        end else begin
            case (state)
                ctrl_pkg::ST_FETCH_ADDR: state <= ctrl_pkg::ST_FETCH_IR;
                ctrl_pkg::ST_FETCH_IR:   state <= ctrl_pkg::ST_DECODE;

                ctrl_pkg::ST_DECODE: begin
                    // IR is valid here, hold the decode for the rest of the instruction
                    instr <= decoded;
                    case (decoded.cls)
                        ctrl_pkg::CLS_ALU_R,
                        ctrl_pkg::CLS_ALU_I,
                        ctrl_pkg::CLS_LOAD,
                        ctrl_pkg::CLS_STORE,
                        ctrl_pkg::CLS_BEQ,
                        ctrl_pkg::CLS_BNE: state <= ctrl_pkg::ST_EXEC;
                        ctrl_pkg::CLS_J,
                        ctrl_pkg::CLS_JR:  state <= ctrl_pkg::ST_JUMP;
                        ctrl_pkg::CLS_JAL: state <= ctrl_pkg::ST_LINK;
                        default: begin
                            state <= ctrl_pkg::ST_TRAP;
                            cause <= ctrl_pkg::CAUSE_ILLEGAL;
                        end
                    endcase
                end

                ctrl_pkg::ST_EXEC: begin
                    if (instr.ovf_trap && overflow) begin
                        state <= ctrl_pkg::ST_TRAP;
                        cause <= ctrl_pkg::CAUSE_OVERFLOW;
                    end else begin
                        case (instr.cls)
                            ctrl_pkg::CLS_LOAD,
                            ctrl_pkg::CLS_STORE: state <= ctrl_pkg::ST_MEM_ACCESS;
                            ctrl_pkg::CLS_BEQ,
                            ctrl_pkg::CLS_BNE:   state <= ctrl_pkg::ST_BRANCH;
                            default:             state <= ctrl_pkg::ST_WRITEBACK;
                        endcase
                    end
                end

                ctrl_pkg::ST_MEM_ACCESS: begin
                    if (instr.cls == ctrl_pkg::CLS_LOAD) begin
                        state <= ctrl_pkg::ST_MEM_WAIT;
                    end else begin
                        state <= ctrl_pkg::ST_FETCH_ADDR;
                    end
                end
                ctrl_pkg::ST_MEM_WAIT: state <= ctrl_pkg::ST_MEM_READBACK;

                // Link writes ra first, the jump follows
                ctrl_pkg::ST_LINK: state <= ctrl_pkg::ST_JUMP;

                default: state <= ctrl_pkg::ST_FETCH_ADDR;
            endcase
        end
    end

endmodule

//--- tb_ctrl.sv
`timescale 1ns/1ps

module tb_ctrl;

    // About twice the cycles that all tests together need
    localparam int TIMEOUT_CYCLES = 300;
    localparam int MAX_INSTR_CYCLES = 12;

    logic                 clk;
    logic                 reset;
    ctrl_pkg::op_field_t  opcode;
    ctrl_pkg::op_field_t  funct;
    ctrl_pkg::alu_flags_t flags;
    ctrl_pkg::mem_ctrl_t  mem_ctrl;
    ctrl_pkg::reg_ctrl_t  reg_ctrl;
    ctrl_pkg::alu_ctrl_t  alu_ctrl;
    ctrl_pkg::pc_ctrl_t   pc_ctrl;

    string cur_test;
    int    test_errs;
    int    n_pass;
    int    n_fail;
    int    cycle_count;
    int    seed;

    // What one instruction did between two ir_wr pulses
    int n_cycles;
    int n_reg_wr;
    int n_mem_wr;
    int n_pc_wr;
    int n_epc_wr;
    int reg_wr_at;
    int pc_wr_at;
    int seen_alu_op;
    int seen_src_a;
    int seen_src_b;
    int seen_decode_wr;
    int seen_wb_sel;
    int seen_reg_dst;
    int seen_addr_sel;
    int seen_pc_src;
    int seen_cause;

    ctrl_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .flags    (flags),
        .mem_ctrl (mem_ctrl),
        .reg_ctrl (reg_ctrl),
        .alu_ctrl (alu_ctrl),
        .pc_ctrl  (pc_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_eq(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("%s: pass", cur_test);
        end else begin
            n_fail++;
            $display("%s: fail with %0d errors", cur_test, test_errs);
        end
    endtask

    // Runs from the decode cycle up to the next fetch's ir_wr
    task automatic run_instr(input ctrl_pkg::op_field_t op, input ctrl_pkg::op_field_t fn,
                             input logic ovf, input logic zero);
        logic done;
        @(posedge clk);
        #1;
        opcode         = op;
        funct          = fn;
        flags.overflow = ovf;
        flags.zero     = zero;
        done           = 1'b0;
        n_cycles       = 0;
        n_reg_wr       = 0;
        n_mem_wr       = 0;
        n_pc_wr        = 0;
        n_epc_wr       = 0;
        reg_wr_at      = 0;
        pc_wr_at       = 0;
        seen_alu_op    = -1;
        seen_src_a     = -1;
        seen_src_b     = -1;
        seen_decode_wr = -1;
        seen_wb_sel    = -1;
        seen_reg_dst   = -1;
        seen_addr_sel  = -1;
        seen_pc_src    = -1;
        seen_cause     = -1;
        while (!done) begin
            @(negedge clk);
            n_cycles++;
            if (mem_ctrl.ir_wr) begin
                done = 1'b1;
            end else if (n_cycles > MAX_INSTR_CYCLES) begin
                $display("%s: no instruction fetch within %0d cycles", cur_test, n_cycles);
                test_errs++;
                done = 1'b1;
            end else begin
                if (n_cycles == 1)
                    seen_decode_wr = int'({reg_ctrl.wr_a, reg_ctrl.wr_b, alu_ctrl.alu_out_wr});
                // Second cycle is the execute step
                if (n_cycles == 2) begin
                    seen_alu_op = int'(alu_ctrl.alu_op);
                    seen_src_a  = int'(alu_ctrl.src_a);
                    seen_src_b  = int'(alu_ctrl.src_b);
                end
                if (reg_ctrl.reg_wr) begin
                    n_reg_wr++;
                    reg_wr_at    = n_cycles;
                    seen_wb_sel  = int'(reg_ctrl.wb_sel);
                    seen_reg_dst = int'(reg_ctrl.reg_dst);
                end
                if (mem_ctrl.mem_wr) begin
                    n_mem_wr++;
                    seen_addr_sel = int'(mem_ctrl.addr_sel);
                end
                if (pc_ctrl.pc_wr) begin
                    n_pc_wr++;
                    pc_wr_at    = n_cycles;
                    seen_pc_src = int'(pc_ctrl.pc_src);
                end
                if (pc_ctrl.epc_wr) begin
                    n_epc_wr++;
                    seen_cause = int'(pc_ctrl.cause);
                end
            end
        end
    endtask

    task automatic reset_and_fetch();
        begin_test("reset_fetch");
        repeat (4) begin
            @(negedge clk);
            check_eq("write enables in reset", 0,
                     int'({mem_ctrl.mem_wr, mem_ctrl.ir_wr, reg_ctrl.reg_wr, reg_ctrl.wr_a,
                           reg_ctrl.wr_b, pc_ctrl.pc_wr, pc_ctrl.epc_wr}));
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_eq("ir_wr first fetch cycle", 0, int'(mem_ctrl.ir_wr));
        check_eq("alu_out_wr first fetch cycle", 1, int'(alu_ctrl.alu_out_wr));
        check_eq("src_b first fetch cycle", int'(ctrl_pkg::SRC_B_FOUR), int'(alu_ctrl.src_b));
        @(negedge clk);
        check_eq("ir_wr second fetch cycle", 1, int'(mem_ctrl.ir_wr));
        check_eq("pc_wr", 1, int'(pc_ctrl.pc_wr));
        check_eq("pc_src", int'(ctrl_pkg::PC_SRC_ALU_OUT), int'(pc_ctrl.pc_src));
        end_test();
    endtask

    task automatic alu_test(input string name, input ctrl_pkg::op_field_t op,
                            input ctrl_pkg::op_field_t fn, input ctrl_pkg::alu_op_t exp_op,
                            input logic is_r, input logic ovf);
        begin_test(name);
        run_instr(op, fn, ovf, 1'b0);
        check_eq("cycles", 5, n_cycles);
        check_eq("decode wr_a wr_b alu_out_wr", 7, seen_decode_wr);
        check_eq("alu_op", int'(exp_op), seen_alu_op);
        check_eq("src_a", int'(ctrl_pkg::SRC_A_REG_A), seen_src_a);
        check_eq("src_b", is_r ? int'(ctrl_pkg::SRC_B_REG_B) : int'(ctrl_pkg::SRC_B_IMM),
                 seen_src_b);
        check_eq("reg_wr pulses", 1, n_reg_wr);
        check_eq("epc_wr pulses", 0, n_epc_wr);
        check_eq("wb_sel", int'(ctrl_pkg::WB_SEL_ALU_OUT), seen_wb_sel);
        check_eq("reg_dst", is_r ? int'(ctrl_pkg::REG_DST_RD) : int'(ctrl_pkg::REG_DST_RT),
                 seen_reg_dst);
        end_test();
    endtask

    task automatic random_alu_test();
        ctrl_pkg::op_field_t functs [5];
        ctrl_pkg::alu_op_t   ops [5];
        int                  idx;
        functs = '{ctrl_pkg::FN_ADD, ctrl_pkg::FN_SUB, ctrl_pkg::FN_AND,
                   ctrl_pkg::FN_OR, ctrl_pkg::FN_SLT};
        ops    = '{ctrl_pkg::ALU_OP_ADD, ctrl_pkg::ALU_OP_SUB, ctrl_pkg::ALU_OP_AND,
                   ctrl_pkg::ALU_OP_OR, ctrl_pkg::ALU_OP_SLT};
        idx    = $unsigned($random(seed)) % 5;
        alu_test("alu_r_random", ctrl_pkg::OP_RTYPE, functs[idx], ops[idx], 1'b1, 1'b0);
    endtask

    task automatic load_test();
        begin_test("lw");
        run_instr(ctrl_pkg::OP_LW, 6'd0, 1'b0, 1'b0);
        check_eq("cycles", 7, n_cycles);
        check_eq("src_b", int'(ctrl_pkg::SRC_B_IMM), seen_src_b);
        check_eq("reg_wr pulses", 1, n_reg_wr);
        check_eq("reg_wr cycle", 5, reg_wr_at);
        check_eq("mem_wr pulses", 0, n_mem_wr);
        check_eq("wb_sel", int'(ctrl_pkg::WB_SEL_MDR), seen_wb_sel);
        check_eq("reg_dst", int'(ctrl_pkg::REG_DST_RT), seen_reg_dst);
        end_test();
    endtask

    task automatic store_test();
        begin_test("sw");
        run_instr(ctrl_pkg::OP_SW, 6'd0, 1'b0, 1'b0);
        check_eq("cycles", 5, n_cycles);
        check_eq("mem_wr pulses", 1, n_mem_wr);
        check_eq("reg_wr pulses", 0, n_reg_wr);
        check_eq("addr_sel", int'(ctrl_pkg::ADDR_SEL_ALU_OUT), seen_addr_sel);
        end_test();
    endtask

    task automatic branch_test(input string name, input ctrl_pkg::op_field_t op,
                               input logic zero, input logic taken);
        begin_test(name);
        run_instr(op, 6'd0, 1'b0, zero);
        check_eq("cycles", 5, n_cycles);
        check_eq("src_b", int'(ctrl_pkg::SRC_B_REG_B), seen_src_b);
        check_eq("pc_wr pulses", taken ? 1 : 0, n_pc_wr);
        if (taken) begin
            check_eq("pc_wr cycle", 3, pc_wr_at);
            check_eq("pc_src", int'(ctrl_pkg::PC_SRC_ALU_OUT), seen_pc_src);
        end
        end_test();
    endtask

    task automatic jump_test(input string name, input ctrl_pkg::op_field_t op,
                             input ctrl_pkg::op_field_t fn, input ctrl_pkg::pc_src_t exp_src);
        begin_test(name);
        run_instr(op, fn, 1'b0, 1'b0);
        check_eq("cycles", 4, n_cycles);
        check_eq("pc_wr pulses", 1, n_pc_wr);
        check_eq("pc_src", int'(exp_src), seen_pc_src);
        check_eq("reg_wr pulses", 0, n_reg_wr);
        end_test();
    endtask

    task automatic jal_test();
        begin_test("jal");
        run_instr(ctrl_pkg::OP_JAL, 6'd0, 1'b0, 1'b0);
        check_eq("cycles", 5, n_cycles);
        check_eq("reg_wr pulses", 1, n_reg_wr);
        check_eq("reg_dst", int'(ctrl_pkg::REG_DST_RA), seen_reg_dst);
        check_eq("wb_sel", int'(ctrl_pkg::WB_SEL_PC), seen_wb_sel);
        check_eq("pc_src", int'(ctrl_pkg::PC_SRC_JUMP_TARGET), seen_pc_src);
        // Link must come before the jump
        check_eq("link before jump", 1, int'(reg_wr_at < pc_wr_at));
        end_test();
    endtask

    task automatic trap_test(input string name, input ctrl_pkg::op_field_t op,
                             input ctrl_pkg::op_field_t fn, input logic ovf,
                             input int exp_cycles, input ctrl_pkg::cause_t exp_cause);
        begin_test(name);
        run_instr(op, fn, ovf, 1'b0);
        check_eq("cycles", exp_cycles, n_cycles);
        check_eq("epc_wr pulses", 1, n_epc_wr);
        check_eq("cause", int'(exp_cause), seen_cause);
        check_eq("pc_wr pulses", 1, n_pc_wr);
        check_eq("pc_src", int'(ctrl_pkg::PC_SRC_TRAP_VECTOR), seen_pc_src);
        check_eq("reg_wr pulses", 0, n_reg_wr);
        end_test();
    endtask

    initial begin
        reset       = 1'b1;
        opcode      = ctrl_pkg::OP_RTYPE;
        funct       = ctrl_pkg::FN_ADD;
        flags       = '0;
        seed        = 32'ha7f857b8;
        n_pass      = 0;
        n_fail      = 0;
        cycle_count = 0;

        reset_and_fetch();

        alu_test("add", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_ADD, ctrl_pkg::ALU_OP_ADD, 1'b1, 1'b0);
        alu_test("sub", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_SUB, ctrl_pkg::ALU_OP_SUB, 1'b1, 1'b0);
        alu_test("and", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_AND, ctrl_pkg::ALU_OP_AND, 1'b1, 1'b0);
        alu_test("or", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_OR, ctrl_pkg::ALU_OP_OR, 1'b1, 1'b0);
        alu_test("slt", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_SLT, ctrl_pkg::ALU_OP_SLT, 1'b1, 1'b0);
        alu_test("addi", ctrl_pkg::OP_ADDI, 6'd0, ctrl_pkg::ALU_OP_ADD, 1'b0, 1'b0);
        alu_test("andi", ctrl_pkg::OP_ANDI, 6'd0, ctrl_pkg::ALU_OP_AND, 1'b0, 1'b0);
        alu_test("ori", ctrl_pkg::OP_ORI, 6'd0, ctrl_pkg::ALU_OP_OR, 1'b0, 1'b0);
        alu_test("slti", ctrl_pkg::OP_SLTI, 6'd0, ctrl_pkg::ALU_OP_SLT, 1'b0, 1'b0);
        random_alu_test();

        load_test();
        store_test();

        branch_test("beq_taken", ctrl_pkg::OP_BEQ, 1'b1, 1'b1);
        branch_test("beq_not_taken", ctrl_pkg::OP_BEQ, 1'b0, 1'b0);
        branch_test("bne_taken", ctrl_pkg::OP_BNE, 1'b0, 1'b1);
        branch_test("bne_not_taken", ctrl_pkg::OP_BNE, 1'b1, 1'b0);

        jump_test("j", ctrl_pkg::OP_J, 6'd0, ctrl_pkg::PC_SRC_JUMP_TARGET);
        jump_test("jr", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_JR, ctrl_pkg::PC_SRC_REG_A);
        jal_test();

        trap_test("illegal_opcode", 6'b111111, 6'd0, 1'b0, 4, ctrl_pkg::CAUSE_ILLEGAL);
        trap_test("illegal_funct", ctrl_pkg::OP_RTYPE, 6'b111111, 1'b0, 4,
                  ctrl_pkg::CAUSE_ILLEGAL);
        trap_test("add_overflow", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_ADD, 1'b1, 5,
                  ctrl_pkg::CAUSE_OVERFLOW);
        // AND has no overflow trap so the flag is ignored
        alu_test("and_overflow", ctrl_pkg::OP_RTYPE, ctrl_pkg::FN_AND, ctrl_pkg::ALU_OP_AND,
                 1'b1, 1'b1);

        $display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
ctrl_pkg.sv
instr_decoder.sv
seq_fsm.sv
ctrl_encoder.sv
ctrl_top.sv
tb_ctrl.sv
